//--- rtl/p4_proc_pkg.sv
package p4_proc_pkg;

    // ==================================================
    // Widths
    // ==================================================
    localparam int KEY_WID      = 4;
    localparam int ACTION_WID   = 12;
    localparam int REG_ADDR_WID = 12;
    localparam int REG_DATA_WID = 32;

    // Port index, carried on tuser
    typedef logic port_t;

    typedef enum logic [1:0] {
        OP_FORWARD = 2'd0,
        OP_SET_TAG = 2'd1,
        OP_DROP    = 2'd2
    } opcode_t;

    // ==================================================
    // Action word
    // ==================================================
    typedef struct packed {
        opcode_t    opcode;
        port_t      port;
        logic [8:0] spare;
    } fwd_view_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [7:0] tag;
        logic [1:0] spare;
    } tag_view_t;

    // Opcode sits at the top in both views
    typedef union packed {
        fwd_view_t fwd_view;
        tag_view_t tag_view;
    } action_u;

    // ==================================================
    // Register map, byte addresses
    // ==================================================
    localparam logic [REG_ADDR_WID-1:0] REG_CTRL           = 12'h000;
    localparam logic [REG_ADDR_WID-1:0] REG_DEFAULT_ACTION = 12'h004;
    localparam logic [REG_ADDR_WID-1:0] REG_DROP_COUNT     = 12'h008;
    localparam logic [REG_ADDR_WID-1:0] REG_PKT_COUNT0     = 12'h00c;
    localparam logic [REG_ADDR_WID-1:0] REG_PKT_COUNT1     = 12'h010;
    // Table entries at four-byte spacing from here
    localparam logic [REG_ADDR_WID-1:0] REG_TABLE_BASE     = 12'h100;

endpackage

//--- rtl/p4_proc_regs.sv
`timescale 1ns/1ps

module p4_proc_regs #(
    parameter int TABLE_DEPTH = 16
) (
    input  logic                                      axil_if,
    input  logic                                      reset,
    input  logic                                      reg_wr,
    input  logic                                      reg_rd,
    input  logic [p4_proc_pkg::REG_ADDR_WID-1:0]      reg_addr,
    input  logic [p4_proc_pkg::REG_DATA_WID-1:0]      reg_wdata,
    output logic [p4_proc_pkg::REG_DATA_WID-1:0]      reg_rdata,
    output logic                                      reg_rvalid,
    input  logic [p4_proc_pkg::KEY_WID-1:0]           tbl_index,
    output p4_proc_pkg::action_u                      tbl_action,
    output p4_proc_pkg::action_u                      default_action,
    output logic                                      enable,
    input  logic                                      pkt_done,
    input  p4_proc_pkg::port_t                        pkt_port,
    input  logic                                      drop
);

    localparam int PAD_WID = p4_proc_pkg::REG_DATA_WID - p4_proc_pkg::ACTION_WID;

    p4_proc_pkg::action_u                  tbl_mem [TABLE_DEPTH];
    logic [p4_proc_pkg::REG_ADDR_WID-1:0]  tbl_off;
    logic [p4_proc_pkg::KEY_WID-1:0]       tbl_addr;
    logic                                  tbl_sel;
    logic [p4_proc_pkg::REG_DATA_WID-1:0]  rd_word;
    logic [31:0]                           drop_count;
    logic [31:0]                           pkt_count0;
    logic [31:0]                           pkt_count1;

    // Table window decode, word aligned and within depth
    assign tbl_off  = reg_addr - p4_proc_pkg::REG_TABLE_BASE;
    assign tbl_addr = tbl_off[p4_proc_pkg::KEY_WID+1:2];
    assign tbl_sel  = (reg_addr >= p4_proc_pkg::REG_TABLE_BASE) && (tbl_off[1:0] == 2'b00) &&
                      ((tbl_off >> 2) < TABLE_DEPTH);

    // Lookup port for match_action
    assign tbl_action = (tbl_index < TABLE_DEPTH) ? tbl_mem[tbl_index] : '0;

    always_ff @(posedge axil_if) begin
        if (reset) begin
            enable         <= 1'b0;
            default_action <= '0;
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                tbl_mem[i] <= '0;
            end
        end else if (reg_wr) begin
            if (reg_addr == p4_proc_pkg::REG_CTRL) begin
                enable <= reg_wdata[0];
            end
            if (reg_addr == p4_proc_pkg::REG_DEFAULT_ACTION) begin
                default_action <= reg_wdata[p4_proc_pkg::ACTION_WID-1:0];
            end
            if (tbl_sel) begin
                tbl_mem[tbl_addr] <= reg_wdata[p4_proc_pkg::ACTION_WID-1:0];
            end
        end
    end

    // ==================================================
    // Counters
    // ==================================================
    always_ff @(posedge axil_if) begin
        if (reset) begin
            drop_count <= '0;
            pkt_count0 <= '0;
            pkt_count1 <= '0;
        end else begin
            if (drop) drop_count <= drop_count + 32'd1;
            if (pkt_done && !pkt_port) pkt_count0 <= pkt_count0 + 32'd1;
            if (pkt_done && pkt_port) pkt_count1 <= pkt_count1 + 32'd1;
        end
    end

    // Read mux, unmapped reads zero
    always_comb begin
        rd_word = '0;
        case (reg_addr)
            p4_proc_pkg::REG_CTRL:           rd_word[0] = enable;
            p4_proc_pkg::REG_DEFAULT_ACTION: rd_word = {{PAD_WID{1'b0}}, default_action};
            p4_proc_pkg::REG_DROP_COUNT:     rd_word = drop_count;
            p4_proc_pkg::REG_PKT_COUNT0:     rd_word = pkt_count0;
            p4_proc_pkg::REG_PKT_COUNT1:     rd_word = pkt_count1;
            default: begin
                if (tbl_sel) rd_word = {{PAD_WID{1'b0}}, tbl_mem[tbl_addr]};
            end
        endcase
    end

    always_ff @(posedge axil_if) begin
        if (reset) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge axil_if) begin
        if (reg_rd) reg_rdata <= rd_word;
    end

    a_no_wr_rd: assert property (@(posedge axil_if) disable iff (reset) !(reg_wr && reg_rd));

endmodule

//--- rtl/p4_proc_ingress_arb.sv
`timescale 1ns/1ps

module p4_proc_ingress_arb #(
    parameter int DATA_WID = 64
) (
    input  logic                  axil_if,
    input  logic                  reset,
    input  logic [DATA_WID-1:0]   in0_tdata,
    input  logic                  in0_tlast,
    input  logic                  in0_tvalid,
    output logic                  in0_tready,
    input  logic [DATA_WID-1:0]   in1_tdata,
    input  logic                  in1_tlast,
    input  logic                  in1_tvalid,
    output logic                  in1_tready,
    output logic [DATA_WID-1:0]   arb_tdata,
    output logic                  arb_tlast,
    output p4_proc_pkg::port_t    arb_tuser,
    output logic                  arb_tvalid,
    input  logic                  arb_tready
);

    logic                 locked;
    p4_proc_pkg::port_t   last_grant;
    p4_proc_pkg::port_t   pick;
    p4_proc_pkg::port_t   sel;

    // Round-robin pick, last grantee loses a tie
    always_comb begin
        if (in0_tvalid && in1_tvalid) begin
            pick = ~last_grant;
        end else begin
            pick = in1_tvalid;
        end
    end

    // Grant frozen from the header until the last beat goes
    assign sel = locked ? last_grant : pick;

    assign arb_tdata  = sel ? in1_tdata : in0_tdata;
    assign arb_tlast  = sel ? in1_tlast : in0_tlast;
    assign arb_tvalid = sel ? in1_tvalid : in0_tvalid;
    assign arb_tuser  = sel;

    assign in0_tready = arb_tready && !sel;
    assign in1_tready = arb_tready && sel;

    always_ff @(posedge axil_if) begin
        if (reset) begin
            locked     <= 1'b0;
            last_grant <= 1'b0;
        end else if (arb_tvalid) begin
            last_grant <= sel;
            // Released only when the last beat transfers
            locked     <= !(arb_tready && arb_tlast);
        end
    end

    a_grant_hold: assert property (@(posedge axil_if) disable iff (reset)
        (arb_tvalid && !(arb_tready && arb_tlast)) |=> (!arb_tvalid || $stable(arb_tuser)));

endmodule

//--- rtl/p4_proc_match_action.sv
`timescale 1ns/1ps

module p4_proc_match_action #(
    parameter int DATA_WID    = 64,
    parameter int TABLE_DEPTH = 16
) (
    input  logic                              axil_if,
    input  logic                              reset,
    input  logic [DATA_WID-1:0]               arb_tdata,
    input  logic                              arb_tlast,
    input  p4_proc_pkg::port_t                arb_tuser,
    input  logic                              arb_tvalid,
    output logic                              arb_tready,
    output logic [p4_proc_pkg::KEY_WID-1:0]   tbl_index,
    input  p4_proc_pkg::action_u              tbl_action,
    input  p4_proc_pkg::action_u              default_action,
    input  logic                              enable,
    output logic [DATA_WID-1:0]               ma_tdata,
    output logic                              ma_tlast,
    output logic [1:0]                        ma_tuser,
    output logic                              ma_tvalid,
    input  logic                              ma_tready,
    output logic                              ma_drop
);

    logic                   header;
    logic                   drop_q;
    p4_proc_pkg::port_t     eport_q;
    logic                   hit;
    p4_proc_pkg::action_u   act;
    logic                   drop_d;
    p4_proc_pkg::port_t     eport_d;
    logic [DATA_WID-1:0]    data_d;
    logic                   in_xfer;

    // Stage accepts when empty or draining
    assign arb_tready = !ma_tvalid || ma_tready;
    assign in_xfer    = arb_tvalid && arb_tready;

    // ==================================================
    // Lookup
    // ==================================================
    assign tbl_index = arb_tdata[p4_proc_pkg::KEY_WID-1:0];
    // Out-of-range keys and a disabled table fall back to default
    assign hit       = enable && (tbl_index < TABLE_DEPTH);
    assign act       = hit ? tbl_action : default_action;

    always_comb begin
        data_d  = arb_tdata;
        drop_d  = drop_q;
        eport_d = eport_q;
        if (header) begin
            drop_d = 1'b0;
            case (act.fwd_view.opcode)
                p4_proc_pkg::OP_FORWARD: begin
                    eport_d = act.fwd_view.port;
                end
                p4_proc_pkg::OP_SET_TAG: begin
                    // Tag rewrite, hairpin to ingress
                    data_d[15:8] = act.tag_view.tag;
                    eport_d      = arb_tuser;
                end
                default: begin
                    drop_d  = 1'b1;
                    eport_d = 1'b0;
                end
            endcase
        end
    end

    // ==================================================
    // Pipeline stage
    // ==================================================
    always_ff @(posedge axil_if) begin
        if (reset) begin
            header    <= 1'b1;
            drop_q    <= 1'b0;
            eport_q   <= 1'b0;
            ma_tvalid <= 1'b0;
        end else begin
            if (in_xfer) begin
                header  <= arb_tlast;
                drop_q  <= drop_d;
                eport_q <= eport_d;
            end
            if (arb_tready) ma_tvalid <= arb_tvalid;
        end
    end

    // Ingress port rides in the upper tuser bit
    always_ff @(posedge axil_if) begin
        if (in_xfer) begin
            ma_tdata <= data_d;
            ma_tlast <= arb_tlast;
            ma_tuser <= {arb_tuser, eport_d};
            ma_drop  <= drop_d;
        end
    end

    a_out_stable: assert property (@(posedge axil_if) disable iff (reset)
        (ma_tvalid && !ma_tready) |=> $stable(ma_tdata));

endmodule

//--- rtl/p4_proc_egress_demux.sv
`timescale 1ns/1ps

module p4_proc_egress_demux #(
    parameter int DATA_WID = 64
) (
    input  logic                  axil_if,
    input  logic                  reset,
    input  logic [DATA_WID-1:0]   ma_tdata,
    input  logic                  ma_tlast,
    input  logic [1:0]            ma_tuser,
    input  logic                  ma_tvalid,
    input  logic                  ma_drop,
    output logic                  ma_tready,
    output logic [DATA_WID-1:0]   out0_tdata,
    output logic                  out0_tlast,
    output p4_proc_pkg::port_t    out0_tuser,
    output logic                  out0_tvalid,
    input  logic                  out0_tready,
    output logic [DATA_WID-1:0]   out1_tdata,
    output logic                  out1_tlast,
    output p4_proc_pkg::port_t    out1_tuser,
    output logic                  out1_tvalid,
    input  logic                  out1_tready,
    output logic                  pkt_done,
    output p4_proc_pkg::port_t    pkt_port,
    output logic                  drop
);

    logic   ma_xfer;
    logic   mid_pkt;
    logic   pkt_drop;

    // Dropped beats are sunk here
    assign ma_tready = ma_drop || (ma_tuser[0] ? out1_tready : out0_tready);
    assign ma_xfer   = ma_tvalid && ma_tready;

    assign out0_tdata  = ma_tdata;
    assign out0_tlast  = ma_tlast;
    assign out0_tuser  = ma_tuser[1];
    assign out0_tvalid = ma_tvalid && !ma_drop && !ma_tuser[0];

    assign out1_tdata  = ma_tdata;
    assign out1_tlast  = ma_tlast;
    assign out1_tuser  = ma_tuser[1];
    assign out1_tvalid = ma_tvalid && !ma_drop && ma_tuser[0];

    // Completion pulses for the counters
    assign pkt_done = ma_xfer && ma_tlast && !ma_drop;
    assign pkt_port = ma_tuser[0];
    assign drop     = ma_xfer && ma_tlast && ma_drop;

    // Packet tracking for the drop consistency check
    always_ff @(posedge axil_if) begin
        if (reset) begin
            mid_pkt  <= 1'b0;
            pkt_drop <= 1'b0;
        end else if (ma_xfer) begin
            mid_pkt  <= !ma_tlast;
            pkt_drop <= ma_drop;
        end
    end

    a_drop_const: assert property (@(posedge axil_if) disable iff (reset)
        (ma_tvalid && mid_pkt) |-> (ma_drop == pkt_drop));

endmodule

//--- rtl/p4_proc.sv
`timescale 1ns/1ps

module p4_proc #(
    parameter int DATA_WID    = 64,
    parameter int TABLE_DEPTH = 16
) (
    input  logic                                   axil_if,
    input  logic                                   reset,
    input  logic [DATA_WID-1:0]                    in0_tdata,
    input  logic                                   in0_tlast,
    input  logic                                   in0_tvalid,
    output logic                                   in0_tready,
    input  logic [DATA_WID-1:0]                    in1_tdata,
    input  logic                                   in1_tlast,
    input  logic                                   in1_tvalid,
    output logic                                   in1_tready,
    output logic [DATA_WID-1:0]                    out0_tdata,
    output logic                                   out0_tlast,
    output p4_proc_pkg::port_t                     out0_tuser,
    output logic                                   out0_tvalid,
    input  logic                                   out0_tready,
    output logic [DATA_WID-1:0]                    out1_tdata,
    output logic                                   out1_tlast,
    output p4_proc_pkg::port_t                     out1_tuser,
    output logic                                   out1_tvalid,
    input  logic                                   out1_tready,
    input  logic                                   reg_wr,
    input  logic                                   reg_rd,
    input  logic [p4_proc_pkg::REG_ADDR_WID-1:0]   reg_addr,
    input  logic [p4_proc_pkg::REG_DATA_WID-1:0]   reg_wdata,
    output logic [p4_proc_pkg::REG_DATA_WID-1:0]   reg_rdata,
    output logic                                   reg_rvalid
);

    // Merged ingress stream
    logic [DATA_WID-1:0]              arb_tdata;
    logic                             arb_tlast;
    p4_proc_pkg::port_t               arb_tuser;
    logic                             arb_tvalid;
    logic                             arb_tready;

    // Processed stream toward egress
    logic [DATA_WID-1:0]              ma_tdata;
    logic                             ma_tlast;
    logic [1:0]                       ma_tuser;
    logic                             ma_tvalid;
    logic                             ma_tready;
    logic                             ma_drop;

    logic [p4_proc_pkg::KEY_WID-1:0]  tbl_index;
    p4_proc_pkg::action_u             tbl_action;
    p4_proc_pkg::action_u             default_action;
    logic                             enable;
    logic                             pkt_done;
    p4_proc_pkg::port_t               pkt_port;
    logic                             drop;

    p4_proc_ingress_arb #(.DATA_WID(DATA_WID)) arb0 (
        .axil_if, .reset,
        .in0_tdata, .in0_tlast, .in0_tvalid, .in0_tready,
        .in1_tdata, .in1_tlast, .in1_tvalid, .in1_tready,
        .arb_tdata, .arb_tlast, .arb_tuser, .arb_tvalid, .arb_tready
    );

    p4_proc_match_action #(.DATA_WID(DATA_WID), .TABLE_DEPTH(TABLE_DEPTH)) ma0 (
        .axil_if, .reset,
        .arb_tdata, .arb_tlast, .arb_tuser, .arb_tvalid, .arb_tready,
        .tbl_index, .tbl_action, .default_action, .enable,
        .ma_tdata, .ma_tlast, .ma_tuser, .ma_tvalid, .ma_tready, .ma_drop
    );

    p4_proc_egress_demux #(.DATA_WID(DATA_WID)) demux0 (
        .axil_if, .reset,
        .ma_tdata, .ma_tlast, .ma_tuser, .ma_tvalid, .ma_drop, .ma_tready,
        .out0_tdata, .out0_tlast, .out0_tuser, .out0_tvalid, .out0_tready,
        .out1_tdata, .out1_tlast, .out1_tuser, .out1_tvalid, .out1_tready,
        .pkt_done, .pkt_port, .drop
    );

    p4_proc_regs #(.TABLE_DEPTH(TABLE_DEPTH)) regs0 (
        .axil_if, .reset,
        .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata, .reg_rvalid,
        .tbl_index, .tbl_action, .default_action, .enable,
        .pkt_done, .pkt_port, .drop
    );

endmodule

//--- verif/tb_p4_proc.sv
`timescale 1ns/1ps

module tb_p4_proc;

    localparam int TBL_DEPTH = 12;
    localparam int TIMEOUT   = 2000;

    logic                axil_if;
    logic                reset;
    logic [1:0][63:0]    in_tdata;
    logic [1:0]          in_tlast;
    logic [1:0]          in_tvalid;
    logic [1:0]          in_tready;
    logic [1:0][63:0]    out_tdata;
    logic [1:0]          out_tlast;
    logic [1:0]          out_tuser;
    logic [1:0]          out_tvalid;
    logic [1:0]          out_tready;
    logic                reg_wr;
    logic                reg_rd;
    logic [11:0]         reg_addr;
    logic [31:0]         reg_wdata;
    logic [31:0]         reg_rdata;
    logic                reg_rvalid;

    integer      seed;
    logic        stall_on;
    // Reference model state
    logic [11:0] tbl_model [16];
    logic [11:0] dflt_model;
    logic        en_model;
    int          cnt_model [2];
    int          drop_model;
    // Expected beats {tlast, data}, indexed by 2 * egress + ingress
    logic [64:0] exp_q [4][$];
    logic [1:0]  mid;
    logic [1:0]  cur_user;

    p4_proc #(.DATA_WID(64), .TABLE_DEPTH(TBL_DEPTH)) dut0 (
        .axil_if, .reset,
        .in0_tdata(in_tdata[0]), .in0_tlast(in_tlast[0]),
        .in0_tvalid(in_tvalid[0]), .in0_tready(in_tready[0]),
        .in1_tdata(in_tdata[1]), .in1_tlast(in_tlast[1]),
        .in1_tvalid(in_tvalid[1]), .in1_tready(in_tready[1]),
        .out0_tdata(out_tdata[0]), .out0_tlast(out_tlast[0]), .out0_tuser(out_tuser[0]),
        .out0_tvalid(out_tvalid[0]), .out0_tready(out_tready[0]),
        .out1_tdata(out_tdata[1]), .out1_tlast(out_tlast[1]), .out1_tuser(out_tuser[1]),
        .out1_tvalid(out_tvalid[1]), .out1_tready(out_tready[1]),
        .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata, .reg_rvalid
    );

    initial begin
        axil_if = 1'b0;
        forever #2 axil_if = ~axil_if;
    end

    // Random egress stalls, only while enabled
    always @(posedge axil_if) begin
        #1;
        out_tready = stall_on ? 2'($random(seed)) : 2'b11;
    end

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopping at first error");
    endtask

    // ==================================================
    // Register access
    // ==================================================
    task automatic reg_write(logic [11:0] addr, logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge axil_if);
        #1;
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(logic [11:0] addr, output logic [31:0] data);
        int n;
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(posedge axil_if);
        #1;
        reg_rd = 1'b0;
        for (n = 0; n < TIMEOUT; n++) begin
            if (reg_rvalid) break;
            @(posedge axil_if);
            #1;
        end
        assert (n < TIMEOUT) else report_failure("Timed out waiting for reg_rvalid");
        data = reg_rdata;
        @(posedge axil_if);
        #1;
    endtask

    task automatic check_reg(string name, logic [11:0] addr, logic [31:0] exp);
        logic [31:0] got;
        reg_read(addr, got);
        assert (got == exp) else
            report_failure($sformatf("[FAIL] reg_rdata (%s) got %h exp %h", name, got, exp));
    endtask

    task automatic set_table(int idx, logic [11:0] act);
        tbl_model[idx] = act;
        reg_write(p4_proc_pkg::REG_TABLE_BASE + 12'(4 * idx), {20'd0, act});
    endtask

    task automatic set_default(logic [11:0] act);
        dflt_model = act;
        reg_write(p4_proc_pkg::REG_DEFAULT_ACTION, {20'd0, act});
    endtask

    task automatic set_enable(logic en);
        en_model = en;
        reg_write(p4_proc_pkg::REG_CTRL, {31'd0, en});
    endtask

    // ==================================================
    // Stream driver and checker
    // ==================================================
    task automatic send_packet(int p, logic [3:0] key, int len);
        logic [63:0] beat;
        logic [11:0] act;
        logic        eg;
        logic        dropped;
        int          n;
        act     = (en_model && key < TBL_DEPTH) ? tbl_model[key] : dflt_model;
        eg      = (act[11:10] == 2'b01) ? p[0] : act[9];
        dropped = act[11];
        if (dropped) drop_model++;
        else cnt_model[eg]++;
        for (int i = 0; i < len; i++) begin
            beat = {$random(seed), $random(seed)};
            if (i == 0) beat[3:0] = key;
            in_tdata[p]  = beat;
            in_tlast[p]  = (i == len - 1);
            in_tvalid[p] = 1'b1;
            // Set-tag rewrites the header tag byte
            if (i == 0 && act[11:10] == 2'b01) beat[15:8] = act[9:2];
            if (!dropped) exp_q[2 * eg + p].push_back({in_tlast[p], beat});
            for (n = 0; n < TIMEOUT; n++) begin
                @(negedge axil_if);
                if (in_tready[p]) break;
            end
            assert (n < TIMEOUT) else report_failure($sformatf("Ingress %0d never ready", p));
            @(posedge axil_if);
            #1;
        end
        in_tvalid[p] = 1'b0;
    endtask

    task automatic check_beat(int e);
        int          qi;
        logic [64:0] exp;
        qi = 2 * e + out_tuser[e];
        if (mid[e]) assert (out_tuser[e] == cur_user[e]) else
            report_failure($sformatf("[FAIL] out%0d_tuser got %h exp %h", e, out_tuser[e],
                                     cur_user[e]));
        assert (exp_q[qi].size() > 0) else
            report_failure($sformatf("Unexpected beat on egress %0d from ingress %0d", e,
                                     out_tuser[e]));
        exp = exp_q[qi].pop_front();
        assert (out_tdata[e] == exp[63:0]) else
            report_failure($sformatf("[FAIL] out%0d_tdata got %h exp %h", e, out_tdata[e],
                                     exp[63:0]));
        assert (out_tlast[e] == exp[64]) else
            report_failure($sformatf("[FAIL] out%0d_tlast got %h exp %h", e, out_tlast[e],
                                     exp[64]));
        mid[e]      = !out_tlast[e];
        cur_user[e] = out_tuser[e];
    endtask

    // Values at the falling edge are the ones that transfer on the next rise
    always @(negedge axil_if) begin
        for (int e = 0; e < 2; e++) begin
            if (!reset && out_tvalid[e] && out_tready[e]) check_beat(e);
        end
    end

    task automatic expect_packet(int e);
        int n;
        for (n = 0; n < TIMEOUT; n++) begin
            if (exp_q[2 * e].size() == 0 && exp_q[2 * e + 1].size() == 0 && !mid[e]) break;
            @(negedge axil_if);
        end
        assert (n < TIMEOUT) else report_failure($sformatf("Egress %0d missing packets", e));
    endtask

    task automatic wait_drain();
        expect_packet(0);
        expect_packet(1);
        repeat (4) @(posedge axil_if);
        #1;
    endtask

    // ==================================================
    // Tests
    // ==================================================
    task automatic test_reset_regs();
        logic [11:0] v;
        assert (out_tvalid == 2'b00) else
            report_failure($sformatf("[FAIL] out_tvalid got %h exp 0", out_tvalid));
        check_reg("REG_DROP_COUNT", p4_proc_pkg::REG_DROP_COUNT, 0);
        check_reg("REG_PKT_COUNT0", p4_proc_pkg::REG_PKT_COUNT0, 0);
        check_reg("REG_PKT_COUNT1", p4_proc_pkg::REG_PKT_COUNT1, 0);
        for (int i = 0; i < 16; i++) begin
            v = 12'($random(seed));
            reg_write(p4_proc_pkg::REG_TABLE_BASE + 12'(4 * i), {20'd0, v});
            // Entries past the table depth are unmapped
            check_reg("table entry", p4_proc_pkg::REG_TABLE_BASE + 12'(4 * i),
                      (i < TBL_DEPTH) ? {20'd0, v} : 32'd0);
        end
        set_default(12'h5a3);
        check_reg("REG_DEFAULT_ACTION", p4_proc_pkg::REG_DEFAULT_ACTION, 32'h5a3);
    endtask

    // Key mod 4 picks forward 0, forward 1, set-tag, drop
    task automatic program_table();
        for (int k = 0; k < TBL_DEPTH; k++) begin
            case (k % 4)
                0: set_table(k, 12'h000);
                1: set_table(k, 12'h200);
                2: set_table(k, {2'b01, 8'(k * 17 + 3), 2'b00});
                default: set_table(k, 12'h800);
            endcase
        end
        set_default(12'h000);
        set_enable(1'b1);
    endtask

    task automatic test_forward();
        for (int i = 0; i < 8; i++) begin
            send_packet(i % 2, 4'((i / 2 % 3) * 4 + (i / 2) % 2), 1 + (i * 3) % 5);
        end
        wait_drain();
    endtask

    task automatic test_set_tag();
        for (int i = 0; i < 6; i++) begin
            send_packet(i % 2, 4'(2 + 4 * (i % 3)), 1 + i % 4);
        end
        wait_drain();
    endtask

    task automatic test_miss_drop();
        set_default(12'h200);
        for (int k = TBL_DEPTH; k < 16; k++) send_packet(k % 2, 4'(k), 2);
        set_default(12'h800);
        send_packet(0, 4'd13, 3);
        send_packet(1, 4'd14, 1);
        send_packet(0, 4'd3, 2);
        send_packet(1, 4'd7, 4);
        set_enable(1'b0);
        set_default({2'b01, 8'h5a, 2'b00});
        send_packet(0, 4'd0, 2);
        send_packet(1, 4'd3, 3);
        set_default(12'h800);
        send_packet(1, 4'd1, 2);
        wait_drain();
        check_reg("REG_DROP_COUNT", p4_proc_pkg::REG_DROP_COUNT, drop_model);
        set_enable(1'b1);
        set_default(12'h000);
    endtask

    task automatic test_concurrent();
        stall_on = 1'b1;
        fork
            for (int i = 0; i < 12; i++) begin
                send_packet(0, 4'($random(seed)), 1 + {$random(seed)} % 6);
            end
            for (int i = 0; i < 12; i++) begin
                send_packet(1, 4'($random(seed)), 1 + {$random(seed)} % 6);
            end
        join
        wait_drain();
        stall_on = 1'b0;
        check_reg("REG_PKT_COUNT0", p4_proc_pkg::REG_PKT_COUNT0, cnt_model[0]);
        check_reg("REG_PKT_COUNT1", p4_proc_pkg::REG_PKT_COUNT1, cnt_model[1]);
        check_reg("REG_DROP_COUNT", p4_proc_pkg::REG_DROP_COUNT, drop_model);
    endtask

    initial begin
        seed       = 32'hfa7b_444f;
        reset      = 1'b1;
        in_tdata   = '0;
        in_tlast   = '0;
        in_tvalid  = '0;
        out_tready = 2'b11;
        reg_wr     = 1'b0;
        reg_rd     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        stall_on   = 1'b0;
        dflt_model = '0;
        en_model   = 1'b0;
        drop_model = 0;
        cnt_model  = '{0, 0};
        mid        = '0;
        cur_user   = '0;
        for (int i = 0; i < 16; i++) tbl_model[i] = '0;
        repeat (8) @(posedge axil_if);
        #1;
        reset = 1'b0;
        test_reset_regs();
        program_table();
        test_forward();
        test_set_tag();
        test_miss_drop();
        test_concurrent();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- files.f
rtl/p4_proc_pkg.sv
rtl/p4_proc_regs.sv
rtl/p4_proc_ingress_arb.sv
rtl/p4_proc_match_action.sv
rtl/p4_proc_egress_demux.sv
rtl/p4_proc.sv
verif/tb_p4_proc.sv

//--- Bender.yml
package:
  name: p4_proc

sources:
  - rtl/p4_proc_pkg.sv
  - rtl/p4_proc_regs.sv
  - rtl/p4_proc_ingress_arb.sv
  - rtl/p4_proc_match_action.sv
  - rtl/p4_proc_egress_demux.sv
  - rtl/p4_proc.sv
  - target: test
    files:
      - verif/tb_p4_proc.sv
